//--- rtl/vec_cfg_pkg.sv
/*
 * Vector unit configuration
 * Size constants and default parameter values shared by the design
 */
package vec_cfg_pkg;

  // One element is one memory word
  localparam int unsigned ElemWidth = 32;

  // Vector register file
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);

  // Word address of the memory port
  localparam int unsigned AddrWidth = 16;

  // Lane count
  localparam int unsigned DefaultNrLanes = 4;
  localparam int unsigned MaxNrLanes     = 16;

endpackage

//--- rtl/vec_isa_pkg.sv
/*
 * Vector instruction set
 * Opcodes, the two views of an instruction word and the host response
 */
package vec_isa_pkg;

  localparam int unsigned InstrWidth = 32;
  localparam int unsigned OpWidth    = 4;

  typedef enum logic [OpWidth-1:0] {
    op_add   = 4'h0,
    op_sub   = 4'h1,
    op_and   = 4'h2,
    op_or    = 4'h3,
    op_xor   = 4'h4,
    op_load  = 4'h5,
    op_store = 4'h6,
    // Element 0 of vs2 back to the host
    op_mvxs  = 4'h7
  } vec_op_e;

  localparam int unsigned ArithRsvdWidth =
    InstrWidth - OpWidth - 3 * vec_cfg_pkg::VRegIdxWidth;
  localparam int unsigned MemRsvdWidth =
    InstrWidth - OpWidth - vec_cfg_pkg::VRegIdxWidth - vec_cfg_pkg::AddrWidth;

  // Register to register form
  typedef struct packed {
    vec_op_e                              opcode;
    logic [vec_cfg_pkg::VRegIdxWidth-1:0] vd;
    logic [vec_cfg_pkg::VRegIdxWidth-1:0] vs1;
    logic [vec_cfg_pkg::VRegIdxWidth-1:0] vs2;
    logic [ArithRsvdWidth-1:0]            rsvd;
  } vec_arith_instr_t;

  // Unit-stride memory form
  typedef struct packed {
    vec_op_e                              opcode;
    logic [vec_cfg_pkg::VRegIdxWidth-1:0] vreg;
    logic [MemRsvdWidth-1:0]              rsvd;
    logic [vec_cfg_pkg::AddrWidth-1:0]    base;
  } vec_mem_instr_t;

  // Opcode sits in the same bits in both views
  typedef union packed {
    vec_arith_instr_t arith;
    vec_mem_instr_t   mem;
  } vec_instr_u;

  typedef struct packed {
    logic                              error;
    logic [vec_cfg_pkg::ElemWidth-1:0] data;
  } vec_resp_t;

endpackage

//--- rtl/vec_pe_if.sv
/*
 * Vector unit internal interfaces
 * vec_pe_if carries issued instructions to the lanes and the load/store unit,
 * vec_lane_if carries element reads and load writes between lanes and LSU
 */
`timescale 1ns/1ns

interface vec_pe_if #(
  parameter int unsigned NrLanes = vec_cfg_pkg::DefaultNrLanes
);

  // Held stable by the sequencer until completion
  logic                                 issue_valid;
  vec_isa_pkg::vec_op_e                 op;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0] vd;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0] vs1;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0] vs2;
  logic [vec_cfg_pkg::AddrWidth-1:0]    base;
  // Completion, one bit per lane
  logic [NrLanes-1:0]                   lane_done;
  logic                                 lsu_done;

  modport seq (
    output issue_valid, op, vd, vs1, vs2, base,
    input  lane_done, lsu_done
  );

  modport lane (
    input  issue_valid, op, vd, vs1, vs2,
    output lane_done
  );

  modport lsu (
    input  issue_valid, op, vd, base,
    output lsu_done
  );

endinterface

interface vec_lane_if #(
  parameter int unsigned NrLanes = vec_cfg_pkg::DefaultNrLanes
);

  // Element of vs2, one word per lane
  logic [NrLanes-1:0][vec_cfg_pkg::ElemWidth-1:0] rd_data;
  // Load write port
  logic [NrLanes-1:0]                             wr_en;
  logic [vec_cfg_pkg::ElemWidth-1:0]              wr_data;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0]           wr_vreg;

  modport lane (
    output rd_data,
    input  wr_en, wr_data, wr_vreg
  );

  modport lsu (
    input  rd_data,
    output wr_en, wr_data, wr_vreg
  );

endinterface

//--- rtl/vec_sequencer.sv
/*
 * Vector sequencer
 * Takes one host instruction at a time, decodes it, issues it to the
 * processing elements, waits for completion and returns the response
 */
`timescale 1ns/1ns

module vec_sequencer #(
  parameter int unsigned NrLanes = vec_cfg_pkg::DefaultNrLanes
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Host request
  input  vec_isa_pkg::vec_instr_u           instr_i,
  input  logic                              valid_i,
  output logic                              ready_o,
  // Host response
  output vec_isa_pkg::vec_resp_t            resp_o,
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i,
  // Processing elements
  vec_pe_if.seq                             pe,
  // Lane 0 element of vs2
  input  logic [vec_cfg_pkg::ElemWidth-1:0] elem0_i
);

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StIssue = 2'd1;
  localparam logic [1:0] StWait  = 2'd2;
  localparam logic [1:0] StResp  = 2'd3;

  logic [1:0]                           state_q, state_d;
  logic                                 accept;
  logic                                 dispatch;
  logic                                 err_d, err_q;
  logic                                 op_is_mem;
  logic                                 all_lanes_done;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0] vd_d, vs1_d, vs2_d;
  logic [vec_cfg_pkg::VRegIdxWidth-1:0] vd_q, vs1_q, vs2_q;
  logic [vec_cfg_pkg::AddrWidth-1:0]    base_q;
  vec_isa_pkg::vec_op_e                 op_q;
  logic [vec_cfg_pkg::ElemWidth-1:0]    resp_data;

  assign ready_o        = (state_q == StIdle);
  assign accept         = valid_i && ready_o;
  assign all_lanes_done = (pe.lane_done == {NrLanes{1'b1}});
  assign op_is_mem      = (op_q == vec_isa_pkg::op_load) || (op_q == vec_isa_pkg::op_store);

  // Decode, picking the union view from the opcode
  always_comb begin
    vd_d     = instr_i.arith.vd;
    vs1_d    = instr_i.arith.vs1;
    vs2_d    = instr_i.arith.vs2;
    dispatch = 1'b0;
    err_d    = 1'b0;
    case (instr_i.arith.opcode)
      vec_isa_pkg::op_add, vec_isa_pkg::op_sub, vec_isa_pkg::op_and,
      vec_isa_pkg::op_or, vec_isa_pkg::op_xor: begin
        dispatch = 1'b1;
      end
      vec_isa_pkg::op_load, vec_isa_pkg::op_store: begin
        // vreg shares its bits with vd
        // Store data leaves through the vs2 read port
        vs2_d    = instr_i.mem.vreg;
        dispatch = 1'b1;
      end
      vec_isa_pkg::op_mvxs: begin
        dispatch = 1'b0;
      end
      default: begin
        err_d = 1'b1;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (accept) begin
          state_d = dispatch ? StIssue : StResp;
        end
      end
      StIssue: state_d = StWait;
      StWait: begin
        if (op_is_mem ? pe.lsu_done : all_lanes_done) begin
          state_d = StResp;
        end
      end
      default: begin
        if (resp_ready_i) begin
          state_d = StIdle;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Fields stay put until the next accepted instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q   <= instr_i.arith.opcode;
      vd_q   <= vd_d;
      vs1_q  <= vs1_d;
      vs2_q  <= vs2_d;
      base_q <= instr_i.mem.base;
      err_q  <= err_d;
    end
  end

  assign pe.issue_valid = (state_q == StIssue);
  assign pe.op          = op_q;
  assign pe.vd          = vd_q;
  assign pe.vs1         = vs1_q;
  assign pe.vs2         = vs2_q;
  assign pe.base        = base_q;

  // Only the scalar move returns data
  assign resp_data    = (op_q == vec_isa_pkg::op_mvxs) ? elem0_i : '0;
  assign resp_o       = '{error: err_q, data: resp_data};
  assign resp_valid_o = (state_q == StResp);

endmodule

//--- rtl/vec_lane.sv
/*
 * Vector lane
 * Holds one element of every vector register and a 32-bit ALU
 */
`timescale 1ns/1ns

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Issued instruction
  vec_pe_if.lane   pe,
  // Element port towards the load/store unit
  vec_lane_if.lane lsu
);

  // Register file slice, one element per vector register
  logic [vec_cfg_pkg::ElemWidth-1:0] vrf_q [vec_cfg_pkg::NrVRegs];

  logic [vec_cfg_pkg::ElemWidth-1:0] op_a;
  logic [vec_cfg_pkg::ElemWidth-1:0] op_b;
  logic [vec_cfg_pkg::ElemWidth-1:0] alu_res;
  logic                              is_arith;
  logic                              done_q;

  assign op_a = vrf_q[pe.vs1];
  assign op_b = vrf_q[pe.vs2];

  always_comb begin
    is_arith = 1'b1;
    alu_res  = '0;
    case (pe.op)
      vec_isa_pkg::op_add: alu_res = op_a + op_b;
      vec_isa_pkg::op_sub: alu_res = op_a - op_b;
      vec_isa_pkg::op_and: alu_res = op_a & op_b;
      vec_isa_pkg::op_or:  alu_res = op_a | op_b;
      vec_isa_pkg::op_xor: alu_res = op_a ^ op_b;
      default: is_arith = 1'b0;
    endcase
  end

  // ALU result or returning load element, never both at once
  always_ff @(posedge clk_i) begin
    if (pe.issue_valid && is_arith) begin
      vrf_q[pe.vd] <= alu_res;
    end else if (lsu.wr_en[LaneId]) begin
      vrf_q[lsu.wr_vreg] <= lsu.wr_data;
    end
  end

  // Done the cycle after the write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= pe.issue_valid && is_arith;
    end
  end

  assign pe.lane_done[LaneId] = done_q;

  // vs2 element, read without delay for stores and the scalar move
  assign lsu.rd_data[LaneId] = op_b;

endmodule

//--- rtl/vec_lsu.sv
/*
 * Vector load/store unit
 * Walks the elements of one register over a request/grant word port,
 * one element per lane at consecutive addresses from the base
 */
`timescale 1ns/1ns

module vec_lsu #(
  parameter int unsigned NrLanes = vec_cfg_pkg::DefaultNrLanes
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Issued instruction
  vec_pe_if.lsu                             pe,
  // Element port towards the lanes
  vec_lane_if.lsu                           lanes,
  // Memory port
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [vec_cfg_pkg::AddrWidth-1:0] mem_addr_o,
  output logic [vec_cfg_pkg::ElemWidth-1:0] mem_wdata_o,
  input  logic                              mem_gnt_i,
  input  logic                              mem_rvalid_i,
  input  logic [vec_cfg_pkg::ElemWidth-1:0] mem_rdata_i
);

  // Counters run up to NrLanes inclusive
  localparam int unsigned         CntWidth = $clog2(NrLanes) + 1;
  localparam logic [CntWidth-1:0] LastElem = CntWidth'(NrLanes - 1);

  logic                busy_q;
  logic                done_q;
  logic                is_store;
  logic                start;
  logic [CntWidth-1:0] req_cnt_q;
  logic [CntWidth-1:0] rsp_cnt_q;
  logic                req_pending;
  logic                req_fire;
  logic                rsp_fire;
  logic                last_gnt;
  logic                last_rvalid;

  assign is_store = (pe.op == vec_isa_pkg::op_store);
  assign start    = pe.issue_valid &&
                    (pe.op == vec_isa_pkg::op_load || pe.op == vec_isa_pkg::op_store);

  // Request side advances on grant only
  assign req_pending = busy_q && (req_cnt_q <= LastElem);
  assign req_fire    = req_pending && mem_gnt_i;
  assign last_gnt    = req_fire && (req_cnt_q == LastElem);

  // Read data arrives one cycle after each grant
  assign rsp_fire    = busy_q && !is_store && mem_rvalid_i;
  assign last_rvalid = rsp_fire && (rsp_cnt_q == LastElem);

  assign mem_req_o  = req_pending;
  assign mem_we_o   = busy_q && is_store;
  assign mem_addr_o = pe.base + vec_cfg_pkg::AddrWidth'(req_cnt_q);

  // Store data from the current lane, load data into the returning lane
  always_comb begin
    mem_wdata_o = '0;
    lanes.wr_en = '0;
    for (int unsigned i = 0; i < NrLanes; i++) begin
      if (req_cnt_q == CntWidth'(i)) begin
        mem_wdata_o = lanes.rd_data[i];
      end
      if (rsp_fire && (rsp_cnt_q == CntWidth'(i))) begin
        lanes.wr_en[i] = 1'b1;
      end
    end
  end

  assign lanes.wr_data = mem_rdata_i;
  assign lanes.wr_vreg = pe.vd;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      // Store ends on its last grant, load on its last rvalid
      done_q <= (is_store && last_gnt) || last_rvalid;
      if (start) begin
        busy_q    <= 1'b1;
        req_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (req_fire) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (rsp_fire) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
        if ((is_store && last_gnt) || last_rvalid) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  assign pe.lsu_done = done_q;

endmodule

//--- rtl/vec_top.sv
/*
 * Vector coprocessor top level
 * Sequencer, NrLanes lanes and the load/store unit behind plain host
 * and memory ports
 */
`timescale 1ns/1ns

module vec_top #(
  parameter int unsigned NrLanes = vec_cfg_pkg::DefaultNrLanes
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Host request
  input  logic [vec_isa_pkg::InstrWidth-1:0] instr_i,
  input  logic                               valid_i,
  output logic                               ready_o,
  // Host response
  output logic                               resp_error_o,
  output logic [vec_cfg_pkg::ElemWidth-1:0]  resp_data_o,
  output logic                               resp_valid_o,
  input  logic                               resp_ready_i,
  // Memory port
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output logic [vec_cfg_pkg::AddrWidth-1:0]  mem_addr_o,
  output logic [vec_cfg_pkg::ElemWidth-1:0]  mem_wdata_o,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rvalid_i,
  input  logic [vec_cfg_pkg::ElemWidth-1:0]  mem_rdata_i
);

  vec_isa_pkg::vec_resp_t resp;

  vec_pe_if   #(.NrLanes(NrLanes)) pe_if ();
  vec_lane_if #(.NrLanes(NrLanes)) lane_if ();

  vec_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i       (clk_i             ),
    .rst_i       (rst_i             ),
    .instr_i     (instr_i           ),
    .valid_i     (valid_i           ),
    .ready_o     (ready_o           ),
    .resp_o      (resp              ),
    .resp_valid_o(resp_valid_o      ),
    .resp_ready_i(resp_ready_i      ),
    .pe          (pe_if             ),
    .elem0_i     (lane_if.rd_data[0])
  );

  assign resp_error_o = resp.error;
  assign resp_data_o  = resp.data;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i(clk_i  ),
      .rst_i(rst_i  ),
      .pe   (pe_if  ),
      .lsu  (lane_if)
    );
  end

  vec_lsu #(
    .NrLanes(NrLanes)
  ) i_lsu (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .pe          (pe_if       ),
    .lanes       (lane_if     ),
    .mem_req_o   (mem_req_o   ),
    .mem_we_o    (mem_we_o    ),
    .mem_addr_o  (mem_addr_o  ),
    .mem_wdata_o (mem_wdata_o ),
    .mem_gnt_i   (mem_gnt_i   ),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_rdata_i )
  );

  // Lane count checks at elaboration
  if (NrLanes == 0)
    $error("[vec_top] At least one lane is needed");

  if (NrLanes != 2**$clog2(NrLanes))
    $error("[vec_top] The number of lanes must be a power of two");

  if (NrLanes > vec_cfg_pkg::MaxNrLanes)
    $error("[vec_top] Too many lanes, MaxNrLanes is the limit");

endmodule

//--- test/vec_properties.sv
/*
 * Vector unit protocol properties
 * Bound to vec_top, covers reset values, memory request stability,
 * response stability and host back-pressure
 */
`timescale 1ns/1ns

module vec_properties (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              host_ready_i,
  input logic                              resp_valid_i,
  input logic                              resp_ready_i,
  input logic                              resp_error_i,
  input logic [vec_cfg_pkg::ElemWidth-1:0] resp_data_i,
  input logic                              mem_req_i,
  input logic                              mem_we_i,
  input logic [vec_cfg_pkg::AddrWidth-1:0] mem_addr_i,
  input logic [vec_cfg_pkg::ElemWidth-1:0] mem_wdata_i,
  input logic                              mem_gnt_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Idle outputs right after a reset cycle
  reset_idle: assert property (@(posedge clk_i)
    rst_i |=> (host_ready_i && !resp_valid_i && !mem_req_i))
    else begin
      fail_cnt++;
      $error("outputs not idle after reset");
    end

  // Request and its fields held until granted
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_req_i && !mem_gnt_i) |=>
      (mem_req_i && $stable(mem_we_i) && $stable(mem_addr_i) &&
       (!mem_we_i || $stable(mem_wdata_i))))
    else begin
      fail_cnt++;
      $error("memory request changed before its grant");
    end

  // Response held while the host is not ready
  resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_valid_i && !resp_ready_i) |=>
      (resp_valid_i && $stable(resp_error_i) && $stable(resp_data_i)))
    else begin
      fail_cnt++;
      $error("response changed while resp_ready_i was low");
    end

  // Host side opens again only after a response handshake
  busy_while_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(host_ready_i) |-> $past(resp_valid_i && resp_ready_i))
    else begin
      fail_cnt++;
      $error("ready_o rose without a completed response");
    end

endmodule

//--- test/tb_vec_top.sv
/*
 * Vector coprocessor testbench
 * Memory model with random grants and host back-pressure, shadow register
 * file and memory, and checks of every response and memory write
 */
`timescale 1ns/1ns

module tb_vec_top;

  localparam int NrLanes  = 4;
  localparam int MemWords = 2 ** vec_cfg_pkg::AddrWidth;
  localparam int NumInstr = 26;
  // 200 cycles per instruction plus reset
  localparam int Timeout  = (NumInstr * 200 + 5) * 40;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [31:0] instr_i;
  logic        valid_i;
  logic        ready_o;
  logic        resp_error_o;
  logic [31:0] resp_data_o;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [15:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;

  integer      seed = 32'hd3aa;
  int          errors = 0;
  int          nr_reads = 0;
  int          nr_writes = 0;
  logic [15:0] cur_base = '0;
  logic        cur_is_mem = 1'b0;
  logic [15:0] addr_offs;

  // Memory model and its shadow
  logic [31:0] mem_q   [MemWords];
  logic [31:0] exp_mem [MemWords];
  // Shadow register file, element i sits in lane i
  logic [31:0] vrf [vec_cfg_pkg::NrVRegs][NrLanes];

  vec_top #(
    .NrLanes(NrLanes)
  ) dut0 (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .instr_i     (instr_i     ),
    .valid_i     (valid_i     ),
    .ready_o     (ready_o     ),
    .resp_error_o(resp_error_o),
    .resp_data_o (resp_data_o ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .mem_req_o   (mem_req_o   ),
    .mem_we_o    (mem_we_o    ),
    .mem_addr_o  (mem_addr_o  ),
    .mem_wdata_o (mem_wdata_o ),
    .mem_gnt_i   (mem_gnt_i   ),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_rdata_i )
  );

  bind vec_top vec_properties props0 (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .host_ready_i(ready_o     ),
    .resp_valid_i(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_error_i(resp_error_o),
    .resp_data_i (resp_data_o ),
    .mem_req_i   (mem_req_o   ),
    .mem_we_i    (mem_we_o    ),
    .mem_addr_i  (mem_addr_o  ),
    .mem_wdata_i (mem_wdata_o ),
    .mem_gnt_i   (mem_gnt_i   )
  );

  always #20 clk_i = ~clk_i;

  // Word memory with random grants, read data one cycle after the grant
  always @(posedge clk_i) begin
    if (rst_i) begin
      mem_gnt_i    <= 1'b0;
      mem_rvalid_i <= 1'b0;
      resp_ready_i <= 1'b0;
    end else begin
      mem_rvalid_i <= 1'b0;
      if (mem_req_o) begin
        assert (cur_is_mem) else begin
          errors++;
          $display("ERROR: memory request at %0t ns without a load or store", $time);
        end
      end
      if (mem_req_o && mem_gnt_i) begin
        addr_offs = mem_addr_o - cur_base;
        assert (addr_offs < NrLanes) else begin
          errors++;
          $display("ERROR: address %h at %0t ns lies outside the vector", mem_addr_o, $time);
        end
        if (mem_we_o) begin
          assert (mem_wdata_o == exp_mem[mem_addr_o]) else begin
            errors++;
            $display("MISMATCH %0t ns: store to %h wrote %h, expected %h", $time,
                     mem_addr_o, mem_wdata_o, exp_mem[mem_addr_o]);
          end
          mem_q[mem_addr_o] = mem_wdata_o;
          nr_writes++;
        end else begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem_q[mem_addr_o];
          nr_reads++;
        end
      end
      mem_gnt_i    <= ($random(seed) & 3) != 0;
      resp_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  function automatic logic [31:0] arith_instr(input vec_isa_pkg::vec_op_e op,
                                              input logic [2:0] vd, input logic [2:0] vs1,
                                              input logic [2:0] vs2);
    vec_isa_pkg::vec_instr_u w;
    w              = '0;
    w.arith.opcode = op;
    w.arith.vd     = vd;
    w.arith.vs1    = vs1;
    w.arith.vs2    = vs2;
    return w;
  endfunction

  function automatic logic [31:0] mem_instr(input vec_isa_pkg::vec_op_e op,
                                            input logic [2:0] vreg, input logic [15:0] base);
    vec_isa_pkg::vec_instr_u w;
    w            = '0;
    w.mem.opcode = op;
    w.mem.vreg   = vreg;
    w.mem.base   = base;
    return w;
  endfunction

  // Lane-wise result expected for one element
  function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
    case (op)
      vec_isa_pkg::op_add: return a + b;
      vec_isa_pkg::op_sub: return a - b;
      vec_isa_pkg::op_and: return a & b;
      vec_isa_pkg::op_or:  return a | b;
      vec_isa_pkg::op_xor: return a ^ b;
      default:             return '0;
    endcase
  endfunction

  // Send one instruction, update the shadow model and check the response
  task automatic run_instr(input logic [31:0] word);
    vec_isa_pkg::vec_instr_u w;
    logic [3:0]  op;
    logic        exp_err;
    logic        chk_data;
    logic [31:0] exp_data;
    int          exp_lat;
    int          exp_reads;
    int          exp_writes;
    int          reads0;
    int          writes0;
    int          lat;
    w          = word;
    op         = w.arith.opcode;
    exp_err    = 1'b0;
    chk_data   = 1'b0;
    exp_data   = '0;
    exp_lat    = 0;
    exp_reads  = 0;
    exp_writes = 0;
    @(posedge clk_i);
    instr_i <= word;
    valid_i <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (!ready_o);
    valid_i    <= 1'b0;
    reads0     = nr_reads;
    writes0    = nr_writes;
    cur_base   = w.mem.base;
    cur_is_mem = 1'b0;
    case (op)
      vec_isa_pkg::op_add, vec_isa_pkg::op_sub, vec_isa_pkg::op_and,
      vec_isa_pkg::op_or, vec_isa_pkg::op_xor: begin
        for (int i = 0; i < NrLanes; i++) begin
          vrf[w.arith.vd][i] = alu_ref(op, vrf[w.arith.vs1][i], vrf[w.arith.vs2][i]);
        end
        exp_lat = 3;
      end
      vec_isa_pkg::op_load: begin
        for (int i = 0; i < NrLanes; i++) begin
          vrf[w.mem.vreg][i] = exp_mem[16'(w.mem.base + i)];
        end
        exp_reads  = NrLanes;
        cur_is_mem = 1'b1;
      end
      vec_isa_pkg::op_store: begin
        for (int i = 0; i < NrLanes; i++) begin
          exp_mem[16'(w.mem.base + i)] = vrf[w.mem.vreg][i];
        end
        exp_writes = NrLanes;
        cur_is_mem = 1'b1;
      end
      vec_isa_pkg::op_mvxs: begin
        chk_data = 1'b1;
        exp_data = vrf[w.arith.vs2][0];
        exp_lat  = 1;
      end
      default: begin
        exp_err = 1'b1;
        exp_lat = 1;
      end
    endcase
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!resp_valid_o);
    assert (resp_error_o == exp_err) else begin
      errors++;
      $display("MISMATCH %0t ns: error bit %b, expected %b", $time, resp_error_o, exp_err);
    end
    if (chk_data) begin
      assert (resp_data_o == exp_data) else begin
        errors++;
        $display("MISMATCH %0t ns: scalar move gave %h, expected %h", $time,
                 resp_data_o, exp_data);
      end
    end
    if (exp_lat > 0) begin
      assert (lat == exp_lat) else begin
        errors++;
        $display("MISMATCH %0t ns: response after %0d cycles, expected %0d", $time,
                 lat, exp_lat);
      end
    end
    while (!resp_ready_i) begin
      @(posedge clk_i);
    end
    assert ((nr_reads - reads0 == exp_reads) && (nr_writes - writes0 == exp_writes))
      else begin
        errors++;
        $display("MISMATCH %0t ns: %0d reads and %0d writes, expected %0d and %0d", $time,
                 nr_reads - reads0, nr_writes - writes0, exp_reads, exp_writes);
      end
  endtask

  initial begin
    rst_i        = 1'b1;
    instr_i      = '0;
    valid_i      = 1'b0;
    resp_ready_i = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (int a = 0; a < MemWords; a++) begin
      mem_q[a]   = $random(seed);
      exp_mem[a] = mem_q[a];
    end
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    run_instr(mem_instr(vec_isa_pkg::op_load, 3'd1, 16'h0010));
    run_instr(mem_instr(vec_isa_pkg::op_load, 3'd2, 16'h0020));
    run_instr(mem_instr(vec_isa_pkg::op_load, 3'd3, 16'h0030));
    run_instr(arith_instr(vec_isa_pkg::op_add, 3'd4, 3'd1, 3'd2));
    run_instr(mem_instr(vec_isa_pkg::op_store, 3'd4, 16'h0100));
    run_instr(arith_instr(vec_isa_pkg::op_sub, 3'd5, 3'd1, 3'd2));
    run_instr(mem_instr(vec_isa_pkg::op_store, 3'd5, 16'h0104));
    run_instr(arith_instr(vec_isa_pkg::op_and, 3'd6, 3'd2, 3'd3));
    run_instr(mem_instr(vec_isa_pkg::op_store, 3'd6, 16'h0108));
    run_instr(arith_instr(vec_isa_pkg::op_or, 3'd7, 3'd1, 3'd3));
    run_instr(mem_instr(vec_isa_pkg::op_store, 3'd7, 16'h010c));
    run_instr(arith_instr(vec_isa_pkg::op_xor, 3'd0, 3'd2, 3'd3));
    run_instr(mem_instr(vec_isa_pkg::op_store, 3'd0, 16'h0110));
    run_instr(arith_instr(vec_isa_pkg::op_mvxs, 3'd0, 3'd0, 3'd3));
    run_instr(arith_instr(vec_isa_pkg::op_mvxs, 3'd0, 3'd0, 3'd4));
    // Undefined opcodes with register fields that must stay untouched
    run_instr(arith_instr(vec_isa_pkg::vec_op_e'(4'h8), 3'd1, 3'd2, 3'd3));
    run_instr(arith_instr(vec_isa_pkg::vec_op_e'(4'hf), 3'd2, 3'd4, 3'd5));
    // Reload data written by an earlier store
    run_instr(mem_instr(vec_isa_pkg::op_load, 3'd5, 16'h0100));
    for (int r = 0; r < vec_cfg_pkg::NrVRegs; r++) begin
      run_instr(mem_instr(vec_isa_pkg::op_store, r[2:0], 16'(16'h0200 + 4 * r)));
    end

    repeat (2) @(posedge clk_i);
    $display("Checks done: %0d value errors, %0d property failures", errors,
             dut0.props0.fail_cnt);
    if (errors == 0 && dut0.props0.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(Timeout);
    $display("ERROR: run did not finish within %0d ns, DUT stopped responding", Timeout);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- compile.f
rtl/vec_cfg_pkg.sv
rtl/vec_isa_pkg.sv
rtl/vec_pe_if.sv
rtl/vec_sequencer.sv
rtl/vec_lane.sv
rtl/vec_lsu.sv
rtl/vec_top.sv
test/vec_properties.sv
test/tb_vec_top.sv

//--- Bender.yml
package:
  name: vec_unit

sources:
  # Packages first, then interfaces and modules
  - files:
      - rtl/vec_cfg_pkg.sv
      - rtl/vec_isa_pkg.sv
      - rtl/vec_pe_if.sv
      - rtl/vec_sequencer.sv
      - rtl/vec_lane.sv
      - rtl/vec_lsu.sv
      - rtl/vec_top.sv

  - target: test
    files:
      - test/vec_properties.sv
      - test/tb_vec_top.sv
